// File: source/isa_pkg.sv
package isa_pkg;

    localparam int ilen = 32;

    // major opcodes kept by the core
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    // alu funct3
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // branch funct3
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;
    localparam logic [2:0] f3_bge = 3'b101;

    localparam logic [2:0] f3_word = 3'b010; // lw / sw width

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [19:0] rest; // rs1, funct3, rd, opcode
        } i;
        struct packed {
            logic [6:0]  imm_hi;
            logic [12:0] regs; // rs2, rs1, funct3
            logic [4:0]  imm_lo;
            logic [6:0]  opcode;
        } s;
        struct packed {
            logic        imm12;
            logic [5:0]  imm10_5;
            logic [12:0] regs;
            logic [3:0]  imm4_1;
            logic        imm11;
            logic [6:0]  opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [11:0] rest; // rd, opcode
        } u;
        struct packed {
            logic        imm20;
            logic [9:0]  imm10_1;
            logic        imm11;
            logic [7:0]  imm19_12;
            logic [11:0] rest;
        } j;
    } insn_u;

endpackage

// File: source/core_pkg.sv
package core_pkg;

    localparam int xlen       = 32;
    localparam int nregs      = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_op_w   = 4;

    localparam logic [alu_op_w-1:0] alu_add    = 4'd0;
    localparam logic [alu_op_w-1:0] alu_sub    = 4'd1;
    localparam logic [alu_op_w-1:0] alu_slt    = 4'd2;
    localparam logic [alu_op_w-1:0] alu_xor    = 4'd3;
    localparam logic [alu_op_w-1:0] alu_or     = 4'd4;
    localparam logic [alu_op_w-1:0] alu_and    = 4'd5;
    localparam logic [alu_op_w-1:0] alu_sll    = 4'd6;
    localparam logic [alu_op_w-1:0] alu_srl    = 4'd7;
    localparam logic [alu_op_w-1:0] alu_sra    = 4'd8;
    localparam logic [alu_op_w-1:0] alu_pass_b = 4'd9; // lui

endpackage

// File: source/ex_bus_if.sv
`timescale 1ns/1ns

interface ex_bus_if import core_pkg::*; ();

    logic                  valid;
    logic [xlen-1:0]       pc;
    logic [alu_op_w-1:0]   alu_op;
    logic [xlen-1:0]       op_a;
    logic [xlen-1:0]       op_b;
    logic [xlen-1:0]       store_data;
    logic [xlen-1:0]       imm;
    logic [reg_addr_w-1:0] rd;
    logic                  rf_we;
    logic                  is_branch;
    logic                  is_jal;
    logic                  is_load;
    logic                  is_store;
    logic [2:0]            br_funct3;

    modport src (output valid, pc, alu_op, op_a, op_b, store_data, imm, rd, rf_we,
                 is_branch, is_jal, is_load, is_store, br_funct3);
    modport dst (input valid, pc, alu_op, op_a, op_b, store_data, imm, rd, rf_we,
                 is_branch, is_jal, is_load, is_store, br_funct3);

endinterface

// File: source/mem_cmd_if.sv
`timescale 1ns/1ns

interface mem_cmd_if import core_pkg::*; ();

    logic            start; // valid load or store held in execute
    logic            we;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic            busy;
    logic [xlen-1:0] rdata;

    modport req (output start, we, addr, wdata, input busy, rdata);
    modport rsp (input start, we, addr, wdata, output busy, rdata);

endinterface

// File: source/pipe_ctrl.sv
`timescale 1ns/1ns

module pipe_ctrl import core_pkg::*; #(
    parameter logic [xlen-1:0] reset_vector = '0
) (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            stall_i,
    input  logic            redirect_i,
    input  logic [xlen-1:0] target_i,
    output logic [xlen-1:0] imem_addr_o,
    output logic [xlen-1:0] fetch_pc_o,
    output logic            id_valid_o
);

    logic [xlen-1:0] pc; // address of the word now on imem_rdata_i
    logic [xlen-1:0] npc;
    logic            redirect_q;
    logic [xlen-1:0] target_q;

    // fetch turns one cycle after execute resolves the branch
    always_ff @(posedge clk_i) begin
        redirect_q <= !rst_i && redirect_i;
        target_q   <= target_i;
    end

    assign npc = rst_i      ? reset_vector :
                 stall_i    ? pc           : // repeat address, data stays put
                 redirect_q ? target_q     :
                              pc + 4;

    always_ff @(posedge clk_i) begin
        pc <= npc;
    end

    assign imem_addr_o = npc;
    assign fetch_pc_o  = pc;

    // two slots behind a taken branch are squashed
    assign id_valid_o = !(rst_i || redirect_i || redirect_q);

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ns

module decode_stage import isa_pkg::*; import core_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  stall_i,
    input  logic                  id_valid_i,
    input  logic [ilen-1:0]       insn_i,
    input  logic [xlen-1:0]       pc_i,
    output logic [reg_addr_w-1:0] rs1_addr_o,
    output logic [reg_addr_w-1:0] rs2_addr_o,
    input  logic [xlen-1:0]       rs1_data_i,
    input  logic [xlen-1:0]       rs2_data_i,
    ex_bus_if.src                 ex
);

    insn_u               insn;
    logic [alu_op_w-1:0] alu_op;
    logic [xlen-1:0]     imm;
    logic                use_imm;
    logic                rf_we;
    logic                is_branch;
    logic                is_jal;
    logic                is_load;
    logic                is_store;

    assign insn       = insn_i;
    assign rs1_addr_o = insn.r.rs1;
    assign rs2_addr_o = insn.r.rs2;

    always_comb begin
        alu_op    = alu_add; // also the address adder for lw / sw
        imm       = '0;
        use_imm   = 1'b0;
        rf_we     = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        case (insn.r.opcode)
            op_lui: begin
                alu_op  = alu_pass_b;
                imm     = {insn.u.imm, 12'b0};
                use_imm = 1'b1;
                rf_we   = 1'b1;
            end
            op_jal: begin
                imm    = {{(xlen-20){insn.j.imm20}}, insn.j.imm19_12, insn.j.imm11,
                          insn.j.imm10_1, 1'b0};
                is_jal = 1'b1;
                rf_we  = 1'b1;
            end
            op_branch: begin
                imm = {{(xlen-12){insn.b.imm12}}, insn.b.imm11, insn.b.imm10_5,
                       insn.b.imm4_1, 1'b0};
                case (insn.r.funct3)
                    f3_beq, f3_bne, f3_blt, f3_bge: is_branch = 1'b1;
                    default: is_branch = 1'b0; // unsigned compares not kept
                endcase
            end
            op_load: begin
                imm     = {{(xlen-12){insn.i.imm[11]}}, insn.i.imm};
                use_imm = 1'b1;
                is_load = (insn.r.funct3 == f3_word);
                rf_we   = is_load;
            end
            op_store: begin
                imm      = {{(xlen-12){insn.s.imm_hi[6]}}, insn.s.imm_hi, insn.s.imm_lo};
                use_imm  = 1'b1;
                is_store = (insn.r.funct3 == f3_word);
            end
            op_imm, op_reg: begin
                imm     = {{(xlen-12){insn.i.imm[11]}}, insn.i.imm};
                use_imm = (insn.r.opcode == op_imm);
                rf_we   = 1'b1;
                case (insn.r.funct3)
                    f3_add_sub: begin
                        alu_op = (!use_imm && insn.r.funct7[5]) ? alu_sub : alu_add;
                    end
                    f3_sll:     alu_op = alu_sll;
                    f3_slt:     alu_op = alu_slt;
                    f3_xor:     alu_op = alu_xor;
                    f3_srl_sra: alu_op = insn.r.funct7[5] ? alu_sra : alu_srl;
                    f3_or:      alu_op = alu_or;
                    f3_and:     alu_op = alu_and;
                    default:    rf_we  = 1'b0; // sltu, sltiu run as no-ops
                endcase
            end
            default: ; // anything else is a no-op
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ex.valid <= 1'b0;
        end else if (!stall_i) begin
            ex.valid <= id_valid_i;
        end
        if (!stall_i) begin
            ex.pc         <= pc_i;
            ex.alu_op     <= alu_op;
            ex.op_a       <= is_jal ? pc_i : rs1_data_i;
            ex.op_b       <= use_imm ? imm : rs2_data_i;
            ex.store_data <= rs2_data_i;
            ex.imm        <= imm;
            ex.rd         <= insn.r.rd;
            ex.rf_we      <= rf_we;
            ex.is_branch  <= is_branch;
            ex.is_jal     <= is_jal;
            ex.is_load    <= is_load;
            ex.is_store   <= is_store;
            ex.br_funct3  <= insn.r.funct3;
        end
    end

endmodule

// File: source/regfile.sv
`timescale 1ns/1ns

module regfile import core_pkg::*; (
    input  logic                  clk_i,
    input  logic [reg_addr_w-1:0] rs1_addr_i,
    input  logic [reg_addr_w-1:0] rs2_addr_i,
    output logic [xlen-1:0]       rs1_data_o,
    output logic [xlen-1:0]       rs2_data_o,
    input  logic                  we_i,
    input  logic [reg_addr_w-1:0] waddr_i,
    input  logic [xlen-1:0]       wdata_i
);

    logic [xlen-1:0] regs [nregs];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            regs[waddr_i] <= wdata_i; // entry 0 is never read back
        end
    end

    // writeback sits in execute, so decode sees the write in the same cycle
    assign rs1_data_o = (rs1_addr_i == '0)                ? '0      :
                        (we_i && waddr_i == rs1_addr_i) ? wdata_i : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0)                ? '0      :
                        (we_i && waddr_i == rs2_addr_i) ? wdata_i : regs[rs2_addr_i];

endmodule

// File: source/execute.sv
`timescale 1ns/1ns

module execute import isa_pkg::*; import core_pkg::*; (
    ex_bus_if.dst                 ex,
    mem_cmd_if.req                mem,
    input  logic                  stall_i,
    output logic                  redirect_o,
    output logic [xlen-1:0]       target_o,
    output logic                  rf_we_o,
    output logic [reg_addr_w-1:0] rf_waddr_o,
    output logic [xlen-1:0]       rf_wdata_o
);

    logic [xlen-1:0] alu_res;
    logic            br_cond;
    logic            taken;

    always_comb begin
        case (ex.alu_op)
            alu_add:    alu_res = ex.op_a + ex.op_b;
            alu_sub:    alu_res = ex.op_a - ex.op_b;
            alu_slt:    alu_res = {{(xlen-1){1'b0}}, $signed(ex.op_a) < $signed(ex.op_b)};
            alu_xor:    alu_res = ex.op_a ^ ex.op_b;
            alu_or:     alu_res = ex.op_a | ex.op_b;
            alu_and:    alu_res = ex.op_a & ex.op_b;
            alu_sll:    alu_res = ex.op_a << ex.op_b[4:0];
            alu_srl:    alu_res = ex.op_a >> ex.op_b[4:0];
            alu_sra:    alu_res = $unsigned($signed(ex.op_a) >>> ex.op_b[4:0]);
            alu_pass_b: alu_res = ex.op_b;
            default:    alu_res = '0;
        endcase
    end

    // op_b holds rs2 for branches
    always_comb begin
        case (ex.br_funct3)
            f3_beq:  br_cond = (ex.op_a == ex.op_b);
            f3_bne:  br_cond = (ex.op_a != ex.op_b);
            f3_blt:  br_cond = ($signed(ex.op_a) < $signed(ex.op_b));
            f3_bge:  br_cond = ($signed(ex.op_a) >= $signed(ex.op_b));
            default: br_cond = 1'b0;
        endcase
    end

    assign taken      = ex.is_jal || (ex.is_branch && br_cond);
    assign redirect_o = ex.valid && taken;
    assign target_o   = ex.pc + ex.imm;

    // lsu command, alu result is the effective address
    assign mem.start = ex.valid && (ex.is_load || ex.is_store);
    assign mem.we    = ex.is_store;
    assign mem.addr  = alu_res;
    assign mem.wdata = ex.store_data;

    assign rf_we_o    = ex.valid && ex.rf_we && !stall_i;
    assign rf_waddr_o = ex.rd;
    assign rf_wdata_o = ex.is_jal  ? ex.pc + 4 : // link
                        ex.is_load ? mem.rdata :
                                     alu_res;

endmodule

// File: source/lsu.sv
`timescale 1ns/1ns

module lsu import core_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_i,
    mem_cmd_if.rsp          mem,
    output logic            dmem_req_o,
    output logic            dmem_we_o,
    output logic [xlen-1:0] dmem_addr_o,
    output logic [xlen-1:0] dmem_wdata_o,
    input  logic            dmem_ack_i,
    input  logic [xlen-1:0] dmem_rdata_i
);

    localparam logic [1:0] st_idle         = 2'd0;
    localparam logic [1:0] st_wait_ack     = 2'd1;
    localparam logic [1:0] st_wait_release = 2'd2;
    localparam logic [1:0] st_done         = 2'd3; // one free cycle, pipeline moves on

    logic [1:0]      state;
    logic [xlen-1:0] rdata_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:         if (mem.start) state <= st_wait_ack;
                st_wait_ack:     if (dmem_ack_i) state <= st_wait_release;
                st_wait_release: if (!dmem_ack_i) state <= st_done;
                default:         state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == st_wait_ack && dmem_ack_i) begin
            rdata_q <= dmem_rdata_i; // valid only while ack is up
        end
    end

    // command is held stable by the stalled execute stage
    assign dmem_req_o   = (state == st_wait_ack);
    assign dmem_we_o    = mem.we;
    assign dmem_addr_o  = mem.addr;
    assign dmem_wdata_o = mem.wdata;

    assign mem.busy  = (state == st_idle) ? mem.start : (state != st_done);
    assign mem.rdata = rdata_q;

endmodule

// File: source/core_top.sv
`timescale 1ns/1ns

module core_top import isa_pkg::*; import core_pkg::*; #(
    parameter logic [xlen-1:0] reset_vector = '0
) (
    input  logic            clk_i,
    input  logic            rst_i,
    output logic [xlen-1:0] imem_addr_o,
    input  logic [ilen-1:0] imem_rdata_i,
    output logic            dmem_req_o,
    output logic            dmem_we_o,
    output logic [xlen-1:0] dmem_addr_o,
    output logic [xlen-1:0] dmem_wdata_o,
    input  logic            dmem_ack_i,
    input  logic [xlen-1:0] dmem_rdata_i
);

    logic                  redirect;
    logic [xlen-1:0]       target;
    logic [xlen-1:0]       fetch_pc;
    logic                  id_valid;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    logic [xlen-1:0]       rf_wdata;

    ex_bus_if  ex_bus ();
    mem_cmd_if mem_cmd ();

    pipe_ctrl #(.reset_vector(reset_vector)) u_pipe_ctrl (
        .clk_i(clk_i), .rst_i(rst_i), .stall_i(mem_cmd.busy),
        .redirect_i(redirect), .target_i(target),
        .imem_addr_o(imem_addr_o), .fetch_pc_o(fetch_pc), .id_valid_o(id_valid)
    );

    decode_stage u_decode (
        .clk_i(clk_i), .rst_i(rst_i), .stall_i(mem_cmd.busy),
        .id_valid_i(id_valid), .insn_i(imem_rdata_i), .pc_i(fetch_pc),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .ex(ex_bus.src)
    );

    regfile u_regfile (
        .clk_i(clk_i), .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata)
    );

    execute u_execute (
        .ex(ex_bus.dst), .mem(mem_cmd.req), .stall_i(mem_cmd.busy),
        .redirect_o(redirect), .target_o(target),
        .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata)
    );

    lsu u_lsu (
        .clk_i(clk_i), .rst_i(rst_i), .mem(mem_cmd.rsp),
        .dmem_req_o(dmem_req_o), .dmem_we_o(dmem_we_o),
        .dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o),
        .dmem_ack_i(dmem_ack_i), .dmem_rdata_i(dmem_rdata_i)
    );

endmodule

// File: bench/core_sva.sv
`timescale 1ns/1ns

module core_sva #(
    parameter logic [31:0] reset_vector = '0
) (
    input logic        clk_i,
    input logic        rst_i,
    input logic [31:0] imem_addr_o,
    input logic        dmem_req_o,
    input logic        dmem_we_o,
    input logic [31:0] dmem_addr_o,
    input logic [31:0] dmem_wdata_o,
    input logic        dmem_ack_i
);

    req_no_rise_on_ack: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(dmem_req_o) |-> !dmem_ack_i)
        else $error("dmem req rose while ack still high");

    req_held_to_ack: assert property (@(posedge clk_i) disable iff (rst_i)
        dmem_req_o && !dmem_ack_i |=> dmem_req_o)
        else $error("dmem req dropped before ack");

    ack_held_to_release: assert property (@(posedge clk_i) disable iff (rst_i)
        dmem_ack_i && dmem_req_o |=> dmem_ack_i)
        else $error("dmem ack dropped before req");

    cmd_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        dmem_req_o && $past(dmem_req_o) |->
            $stable(dmem_addr_o) && $stable(dmem_wdata_o) && $stable(dmem_we_o))
        else $error("dmem command changed while req high");

    fetch_in_reset: assert property (@(posedge clk_i)
        rst_i |-> imem_addr_o == reset_vector)
        else $error("imem address left the reset vector during reset");

endmodule

bind core_top core_sva #(.reset_vector(reset_vector)) u_core_sva (
    .clk_i(clk_i), .rst_i(rst_i), .imem_addr_o(imem_addr_o),
    .dmem_req_o(dmem_req_o), .dmem_we_o(dmem_we_o), .dmem_addr_o(dmem_addr_o),
    .dmem_wdata_o(dmem_wdata_o), .dmem_ack_i(dmem_ack_i)
);

// File: bench/tb_core.sv
`timescale 1ns/1ns

module tb_core;

    localparam logic [6:0] opc_imm  = 7'h13;
    localparam logic [6:0] opc_reg  = 7'h33;
    localparam logic [6:0] opc_load = 7'h03;
    localparam logic [31:0] nop     = 32'h0000_0013; // addi x0, x0, 0

    logic        clk_i = 1'b0;
    logic        rst_i;
    logic [31:0] imem_addr_o;
    logic [31:0] imem_rdata_i;
    logic        dmem_req_o;
    logic        dmem_we_o;
    logic [31:0] dmem_addr_o;
    logic [31:0] dmem_wdata_o;
    logic        dmem_ack_i;
    logic [31:0] dmem_rdata_i;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] log_addr[$];
    logic [31:0] log_data[$];
    logic [31:0] exp_addr[$];
    logic [31:0] exp_data[$];
    integer      seed;
    int          wp;
    int          dm_state;
    int          dm_cnt;
    int          errors;
    int          timeouts;

    core_top #(.reset_vector(32'h0)) DUT (
        .clk_i(clk_i), .rst_i(rst_i),
        .imem_addr_o(imem_addr_o), .imem_rdata_i(imem_rdata_i),
        .dmem_req_o(dmem_req_o), .dmem_we_o(dmem_we_o), .dmem_addr_o(dmem_addr_o),
        .dmem_wdata_o(dmem_wdata_o), .dmem_ack_i(dmem_ack_i), .dmem_rdata_i(dmem_rdata_i)
    );

    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] itype_insn(logic [11:0] imm, logic [4:0] rs1,
                                               logic [2:0] f3, logic [4:0] rd,
                                               logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] rtype_insn(logic [6:0] f7, logic [4:0] rs2,
                                               logic [4:0] rs1, logic [2:0] f3,
                                               logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_reg};
    endfunction

    function automatic logic [31:0] stype_insn(logic [11:0] imm, logic [4:0] rs2,
                                               logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23}; // sw
    endfunction

    function automatic logic [31:0] btype_insn(logic [12:0] imm, logic [4:0] rs2,
                                               logic [4:0] rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] utype_insn(logic [19:0] imm, logic [4:0] rd);
        return {imm, rd, 7'h37}; // lui
    endfunction

    function automatic logic [31:0] jtype_insn(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    function automatic logic [31:0] fill_word(logic [31:0] addr);
        return (addr * 32'h9e37_79b9) ^ 32'h5bd1_e995;
    endfunction

    function automatic bit cond_holds(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            default: return $signed(a) >= $signed(b);
        endcase
    endfunction

    // data slave with a four-phase handshake and random ack timing
    task automatic serve_dmem;
        if (rst_i) begin
            dmem_ack_i <= 1'b0;
            dm_state = 0;
        end else begin
            case (dm_state)
                0: if (dmem_req_o) begin
                    dm_cnt = {$random(seed)} % 6;
                    dm_state = 1;
                end
                1: if (dm_cnt == 0) begin
                    if (dmem_we_o) begin
                        dmem[dmem_addr_o[9:2]] = dmem_wdata_o;
                        log_addr.push_back(dmem_addr_o);
                        log_data.push_back(dmem_wdata_o);
                    end else begin
                        dmem_rdata_i <= dmem[dmem_addr_o[9:2]];
                    end
                    dmem_ack_i <= 1'b1;
                    dm_state = 2;
                end else begin
                    dm_cnt--;
                end
                2: if (!dmem_req_o) begin
                    dm_cnt = {$random(seed)} % 6;
                    dm_state = 3;
                end
                default: if (dm_cnt == 0) begin
                    dmem_ack_i <= 1'b0;
                    dm_state = 0;
                end else begin
                    dm_cnt--;
                end
            endcase
        end
    endtask

    always @(posedge clk_i) begin
        imem_rdata_i <= imem[imem_addr_o[9:2]]; // one cycle read latency
        serve_dmem();
    end

    task automatic emit(input logic [31:0] insn);
        imem[wp[7:0]] = insn;
        wp++;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // holds the core in reset while a new program is written
    task automatic begin_program;
        @(posedge clk_i) rst_i <= 1'b1;
        @(posedge clk_i);
        for (int i = 0; i < 256; i++) begin
            imem[i[7:0]] = nop;
            dmem[i[7:0]] = fill_word(i * 4);
        end
        wp = 0;
        log_addr.delete();
        log_data.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic run_program;
        emit(jtype_insn(21'd0, 5'd0)); // jal x0, 0 parks the core
        for (int i = 0; i < 7; i++) begin
            @(negedge clk_i);
            assert (imem_addr_o == 32'h0 && !dmem_req_o) else begin
                errors++;
                $display("Mismatch at %0t: in reset imem_addr_o=%h dmem_req_o=%b",
                         $time, imem_addr_o, dmem_req_o);
            end
        end
        @(posedge clk_i) rst_i <= 1'b0;
        @(negedge clk_i);
        assert (!dmem_req_o) else begin
            errors++;
            $display("Mismatch at %0t: dmem_req_o high right after reset", $time);
        end
    endtask

    task automatic wait_and_check(input string name);
        int cyc;
        cyc = 0;
        while (log_addr.size() < exp_addr.size() && cyc < 4000) begin
            @(posedge clk_i);
            cyc++;
        end
        if (log_addr.size() < exp_addr.size()) begin
            timeouts++;
            $display("%s: timed out with %0d of %0d stores seen", name, log_addr.size(),
                     exp_addr.size());
        end
        repeat (60) @(posedge clk_i); // stray stores would land here
        @(negedge clk_i);
        assert (log_addr.size() == exp_addr.size()) else begin
            errors++;
            $display("Mismatch at %0t: %s logged %0d stores, expected %0d", $time, name,
                     log_addr.size(), exp_addr.size());
        end
        for (int i = 0; i < log_addr.size() && i < exp_addr.size(); i++) begin
            assert (log_addr[i] == exp_addr[i] && log_data[i] == exp_data[i]) else begin
                errors++;
                $display("Mismatch at %0t: %s store %0d got %h <- %h, expected %h <- %h",
                         $time, name, i, log_addr[i], log_data[i], exp_addr[i], exp_data[i]);
            end
        end
    endtask

    task automatic reset_behavior;
        begin_program();
        emit(stype_insn(12'h0fc, 5'd0, 5'd0)); // first word after reset must run
        expect_store(32'h0fc, 32'h0);
        run_program();
        wait_and_check("reset");
    endtask

    // result lands in x10 and sw stores it to the next slot
    task automatic compute_and_store(input logic [31:0] insn, input logic [31:0] result);
        logic [31:0] addr;
        addr = 32'h100 + 4 * exp_addr.size();
        emit(insn);
        emit(stype_insn(addr[11:0], 5'd10, 5'd0));
        expect_store(addr, result);
    endtask

    task automatic alu_ops;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        a = 32'h8765_4321;
        b = 32'hffff_fffb; // -5
        c = 32'd7;
        begin_program();
        emit(utype_insn(20'h87654, 5'd1));
        emit(itype_insn(12'h321, 5'd1, 3'b000, 5'd1, opc_imm));
        emit(itype_insn(12'hffb, 5'd0, 3'b000, 5'd2, opc_imm));
        emit(itype_insn(12'h007, 5'd0, 3'b000, 5'd3, opc_imm));
        compute_and_store(utype_insn(20'habcde, 5'd10), 32'habcd_e000);
        compute_and_store(itype_insn(12'hf9c, 5'd1, 3'b000, 5'd10, opc_imm), a - 32'd100);
        compute_and_store(itype_insn(12'hffc, 5'd2, 3'b010, 5'd10, opc_imm), 32'd1); // -5 < -4
        compute_and_store(itype_insn(12'h5a5, 5'd1, 3'b100, 5'd10, opc_imm), a ^ 32'h5a5);
        compute_and_store(itype_insn(12'h0f0, 5'd2, 3'b110, 5'd10, opc_imm), b | 32'hf0);
        compute_and_store(itype_insn(12'h0ff, 5'd1, 3'b111, 5'd10, opc_imm), a & 32'hff);
        compute_and_store(itype_insn(12'h004, 5'd1, 3'b001, 5'd10, opc_imm), a << 4);
        compute_and_store(itype_insn(12'h008, 5'd1, 3'b101, 5'd10, opc_imm), a >> 8);
        compute_and_store(itype_insn(12'h408, 5'd1, 3'b101, 5'd10, opc_imm),
                          $unsigned($signed(a) >>> 8));
        compute_and_store(rtype_insn(7'h00, 5'd2, 5'd1, 3'b000, 5'd10), a + b);
        compute_and_store(rtype_insn(7'h20, 5'd3, 5'd1, 3'b000, 5'd10), a - c);
        compute_and_store(rtype_insn(7'h00, 5'd3, 5'd2, 3'b010, 5'd10), 32'd1);
        compute_and_store(rtype_insn(7'h00, 5'd2, 5'd1, 3'b100, 5'd10), a ^ b);
        compute_and_store(rtype_insn(7'h00, 5'd3, 5'd1, 3'b110, 5'd10), a | c);
        compute_and_store(rtype_insn(7'h00, 5'd2, 5'd1, 3'b111, 5'd10), a & b);
        compute_and_store(rtype_insn(7'h00, 5'd3, 5'd1, 3'b001, 5'd10), a << 7);
        compute_and_store(rtype_insn(7'h00, 5'd3, 5'd1, 3'b101, 5'd10), a >> 7);
        compute_and_store(rtype_insn(7'h20, 5'd3, 5'd2, 3'b101, 5'd10),
                          $unsigned($signed(b) >>> 7));
        run_program();
        wait_and_check("alu");
    endtask

    // branch +8 skips one sw and always reaches the second
    task automatic skip_pair(input logic [2:0] f3, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [31:0] va,
                             input logic [31:0] vb, input int idx);
        logic [31:0] slot;
        slot = 32'h200 + 8 * idx;
        emit(btype_insn(13'd8, rs2, rs1, f3));
        emit(stype_insn(slot[11:0], 5'd1, 5'd0));
        emit(stype_insn(slot[11:0] + 12'd4, 5'd1, 5'd0));
        if (!cond_holds(f3, va, vb)) begin
            expect_store(slot, 32'd5);
        end
        expect_store(slot + 32'd4, 32'd5);
    endtask

    task automatic branch_paths;
        logic [31:0] v1;
        logic [31:0] v2;
        v1 = 32'd5;
        v2 = 32'hffff_fffd;
        begin_program();
        emit(itype_insn(12'h005, 5'd0, 3'b000, 5'd1, opc_imm));
        emit(itype_insn(12'hffd, 5'd0, 3'b000, 5'd2, opc_imm));
        skip_pair(3'b000, 5'd1, 5'd1, v1, v1, 0);
        skip_pair(3'b000, 5'd1, 5'd2, v1, v2, 1);
        skip_pair(3'b001, 5'd1, 5'd2, v1, v2, 2);
        skip_pair(3'b001, 5'd1, 5'd1, v1, v1, 3);
        skip_pair(3'b100, 5'd2, 5'd1, v2, v1, 4);
        skip_pair(3'b100, 5'd1, 5'd2, v1, v2, 5);
        skip_pair(3'b101, 5'd1, 5'd2, v1, v2, 6);
        skip_pair(3'b101, 5'd2, 5'd1, v2, v1, 7);
        run_program();
        wait_and_check("branch");
    endtask

    task automatic jal_link;
        logic [31:0] jal_pc;
        begin_program();
        emit(nop);
        emit(nop);
        jal_pc = 4 * wp;
        emit(jtype_insn(21'd8, 5'd5)); // jal x5, +8
        emit(stype_insn(12'h284, 5'd0, 5'd0));
        emit(stype_insn(12'h280, 5'd5, 5'd0));
        expect_store(32'h280, jal_pc + 32'd4);
        run_program();
        wait_and_check("jal");
    endtask

    task automatic load_use_backpressure;
        logic [31:0] la;
        logic [31:0] sa;
        begin_program();
        emit(itype_insn(12'h123, 5'd0, 3'b000, 5'd7, opc_imm));
        for (int i = 0; i < 6; i++) begin
            la = 32'h300 + 4 * i;
            sa = 32'h380 + 4 * i;
            emit(itype_insn(la[11:0], 5'd0, 3'b010, 5'd5, opc_load)); // lw x5
            emit(rtype_insn(7'h00, 5'd7, 5'd5, 3'b000, 5'd6));       // add x6, x5, x7
            emit(stype_insn(sa[11:0], 5'd6, 5'd0));
            expect_store(sa, fill_word(la) + 32'h123);
        end
        run_program();
        wait_and_check("load_use");
    endtask

    initial begin
        seed         = 32'hb70e_e9c5;
        rst_i        = 1'b1;
        imem_rdata_i = nop;
        dmem_ack_i   = 1'b0;
        dmem_rdata_i = 32'h0;
        errors       = 0;
        timeouts     = 0;
        dm_state     = 0;
        dm_cnt       = 0;
        wp           = 0;
        reset_behavior();
        alu_ops();
        branch_paths();
        jal_link();
        load_use_backpressure();
        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
source/isa_pkg.sv
source/core_pkg.sv
source/ex_bus_if.sv
source/mem_cmd_if.sv
source/pipe_ctrl.sv
source/decode_stage.sv
source/regfile.sv
source/execute.sv
source/lsu.sv
source/core_top.sv
bench/core_sva.sv
bench/tb_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_core -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1

if grep -q "TB PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
